/* rtl/bflyNet.sv */
// Radix-2 butterfly write network
`timescale 1ns/1ns
module bflyNet
  import bflyPkg::*;
(
  input  logic                clk_i,
  input  logic                rstN_i,
  // Initiator side
  input  logic [NumPorts-1:0] valid_i,
  output logic [NumPorts-1:0] ready_o,
  input  addrT [NumPorts-1:0] tgtAddr_i,
  input  dataT [NumPorts-1:0] wdata_i,
  // Target side
  output logic [NumPorts-1:0] valid_o,
  input  logic [NumPorts-1:0] ready_i,
  output iniT  [NumPorts-1:0] iniAddr_o,
  output dataT [NumPorts-1:0] wdata_o
);

  // Layer ports, index is 2 * switch + port
  logic [NumStages-1:0][NumPorts-1:0] stValidIn;
  logic [NumStages-1:0][NumPorts-1:0] stReadyOut;
  addrT [NumStages-1:0][NumPorts-1:0] stTgtIn;
  iniT  [NumStages-1:0][NumPorts-1:0] stIniIn;
  dataT [NumStages-1:0][NumPorts-1:0] stDataIn;
  logic [NumStages-1:0][NumPorts-1:0] stValidOut;
  logic [NumStages-1:0][NumPorts-1:0] stReadyIn;
  addrT [NumStages-1:0][NumPorts-1:0] stTgtOut;
  iniT  [NumStages-1:0][NumPorts-1:0] stIniOut;
  dataT [NumStages-1:0][NumPorts-1:0] stDataOut;

  // Initiator i enters at switch i/2, port i%2, tagged with its number
  for (genvar i = 0; i < NumPorts; i++) begin : genInputs
    assign stValidIn[0][i] = valid_i[i];
    assign stTgtIn[0][i]   = tgtAddr_i[i];
    assign stIniIn[0][i]   = iniT'(i);
    assign stDataIn[0][i]  = wdata_i[i];
    assign ready_o[i]      = stReadyOut[0][i];
  end

  // Last layer port j is target j, so the address is no longer needed
  for (genvar j = 0; j < NumPorts; j++) begin : genOutputs
    assign valid_o[j]                = stValidOut[NumStages-1][j];
    assign iniAddr_o[j]              = stIniOut[NumStages-1][j];
    assign wdata_o[j]                = stDataOut[NumStages-1][j];
    assign stReadyIn[NumStages-1][j] = ready_i[j];
  end

  // Butterfly permutation between neighbouring layers
  for (genvar l = 0; l < NumStages - 1; l++) begin : genLink
    localparam int unsigned Pow = 2 ** (NumStages - 2 - l);
    for (genvar r = 0; r < NumSwitches; r++) begin : genSwitch
      for (genvar s = 0; s < 2; s++) begin : genPort
        localparam int unsigned DstSwitch = Pow * s + (r % Pow) + (r / (2 * Pow)) * 2 * Pow;
        localparam int unsigned DstPort   = (r / Pow) % 2;
        localparam int unsigned Src       = 2 * r + s;
        localparam int unsigned Dst       = 2 * DstSwitch + DstPort;

        assign stValidIn[l+1][Dst] = stValidOut[l][Src];
        assign stTgtIn[l+1][Dst]   = stTgtOut[l][Src];
        assign stIniIn[l+1][Dst]   = stIniOut[l][Src];
        assign stDataIn[l+1][Dst]  = stDataOut[l][Src];
        // Ready runs back along the same link
        assign stReadyIn[l][Src]   = stReadyOut[l+1][Dst];
      end
    end
  end

  for (genvar l = 0; l < NumStages; l++) begin : genStage
    bflyStage #(
      .StageIdx(l)
    ) bflyStage_inst (
      .clk_i    (clk_i),
      .rstN_i   (rstN_i),
      .valid_i  (stValidIn[l]),
      .ready_o  (stReadyOut[l]),
      .tgtAddr_i(stTgtIn[l]),
      .iniAddr_i(stIniIn[l]),
      .data_i   (stDataIn[l]),
      .valid_o  (stValidOut[l]),
      .ready_i  (stReadyIn[l]),
      .tgtAddr_o(stTgtOut[l]),
      .iniAddr_o(stIniOut[l]),
      .data_o   (stDataOut[l])
    );
  end

endmodule

/* rtl/bflyPkg.sv */
// Butterfly network definitions
package bflyPkg;

  // Network size
  localparam int unsigned NumPorts    = 8;
  localparam int unsigned NumStages   = $clog2(NumPorts);
  localparam int unsigned NumSwitches = NumPorts / 2;

  // Field widths
  localparam int unsigned AddrWidth = $clog2(NumPorts);
  localparam int unsigned IniWidth  = $clog2(NumPorts);
  localparam int unsigned DataWidth = 32;

  // Target address, initiator number and data as one word
  localparam int unsigned FlitWidth = AddrWidth + IniWidth + DataWidth;

  // Bit l set adds spill registers behind layer l, layer 0 at the initiators
  localparam logic [NumStages-1:0] SpillMask = 3'b010;

  // Target address
  typedef logic [AddrWidth-1:0] addrT;

  // Initiator number
  typedef logic [IniWidth-1:0] iniT;

  // Write data
  typedef logic [DataWidth-1:0] dataT;

  // Flit as stored in a spill register
  typedef logic [FlitWidth-1:0] flitT;

endpackage

/* rtl/bflyStage.sv */
// Butterfly network layer
`timescale 1ns/1ns
module bflyStage
  import bflyPkg::*;
#(
  parameter int unsigned StageIdx = 0
) (
  input  logic                clk_i,
  input  logic                rstN_i,
  // Layer inputs
  input  logic [NumPorts-1:0] valid_i,
  output logic [NumPorts-1:0] ready_o,
  input  addrT [NumPorts-1:0] tgtAddr_i,
  input  iniT  [NumPorts-1:0] iniAddr_i,
  input  dataT [NumPorts-1:0] data_i,
  // Layer outputs
  output logic [NumPorts-1:0] valid_o,
  input  logic [NumPorts-1:0] ready_i,
  output addrT [NumPorts-1:0] tgtAddr_o,
  output iniT  [NumPorts-1:0] iniAddr_o,
  output dataT [NumPorts-1:0] data_o
);

  // Address bit steered on here, MSB in the first layer
  localparam int unsigned AddrBit = AddrWidth - 1 - StageIdx;

  logic [NumPorts-1:0] swValid;
  logic [NumPorts-1:0] swReady;
  addrT [NumPorts-1:0] swTgtAddr;
  iniT  [NumPorts-1:0] swIniAddr;
  dataT [NumPorts-1:0] swData;

  for (genvar r = 0; r < NumSwitches; r++) begin : genSwitch
    bflySwitch #(
      .AddrBit(AddrBit)
    ) bflySwitch_inst (
      .clk_i    (clk_i),
      .rstN_i   (rstN_i),
      .valid_i  (valid_i[2*r +: 2]),
      .ready_o  (ready_o[2*r +: 2]),
      .tgtAddr_i(tgtAddr_i[2*r +: 2]),
      .iniAddr_i(iniAddr_i[2*r +: 2]),
      .data_i   (data_i[2*r +: 2]),
      .valid_o  (swValid[2*r +: 2]),
      .ready_i  (swReady[2*r +: 2]),
      .tgtAddr_o(swTgtAddr[2*r +: 2]),
      .iniAddr_o(swIniAddr[2*r +: 2]),
      .data_o   (swData[2*r +: 2])
    );
  end

  if (SpillMask[StageIdx]) begin : genSpill
    for (genvar p = 0; p < NumPorts; p++) begin : genPort
      flitT flitIn;
      flitT flitOut;

      assign flitIn = {swTgtAddr[p], swIniAddr[p], swData[p]};

      spillReg spillReg_inst (
        .clk_i  (clk_i),
        .rstN_i (rstN_i),
        .valid_i(swValid[p]),
        .ready_o(swReady[p]),
        .data_i (flitIn),
        .valid_o(valid_o[p]),
        .ready_i(ready_i[p]),
        .data_o (flitOut)
      );

      assign {tgtAddr_o[p], iniAddr_o[p], data_o[p]} = flitOut;
    end
  end else begin : genBypass
    // Purely combinational layer
    assign valid_o   = swValid;
    assign swReady   = ready_i;
    assign tgtAddr_o = swTgtAddr;
    assign iniAddr_o = swIniAddr;
    assign data_o    = swData;
  end

endmodule

/* rtl/bflySwitch.sv */
// Two-by-two butterfly switchbox
`timescale 1ns/1ns
module bflySwitch
  import bflyPkg::*;
#(
  parameter int unsigned AddrBit = 0
) (
  input  logic           clk_i,
  input  logic           rstN_i,
  // Input ports
  input  logic [1:0]     valid_i,
  output logic [1:0]     ready_o,
  input  addrT [1:0]     tgtAddr_i,
  input  iniT  [1:0]     iniAddr_i,
  input  dataT [1:0]     data_i,
  // Output ports
  output logic [1:0]     valid_o,
  input  logic [1:0]     ready_i,
  output addrT [1:0]     tgtAddr_o,
  output iniT  [1:0]     iniAddr_o,
  output dataT [1:0]     data_o
);

  // Output requested by each input
  logic [1:0]      outSel;
  // Requests seen by each output, indexed [output][input]
  logic [1:0][1:0] req;
  // Winning input per output
  logic [1:0]      gntIdx;
  // Preferred input per output
  logic [1:0]      rrPtrQ;
  // Grant held while an output waits for ready
  logic [1:0]      lockQ;
  logic [1:0]      lockIdxQ;

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      outSel[i] = tgtAddr_i[i][AddrBit];
    end
  end

  always_comb begin
    for (int o = 0; o < 2; o++) begin
      for (int i = 0; i < 2; i++) begin
        req[o][i] = valid_i[i] && (outSel[i] == 1'(o));
      end
    end
  end

  // Round-robin pick, frozen while the output is stalled
  always_comb begin
    for (int o = 0; o < 2; o++) begin
      if (lockQ[o]) begin
        gntIdx[o] = lockIdxQ[o];
      end else if (req[o][rrPtrQ[o]]) begin
        gntIdx[o] = rrPtrQ[o];
      end else begin
        gntIdx[o] = ~rrPtrQ[o];
      end
      valid_o[o]   = |req[o];
      tgtAddr_o[o] = tgtAddr_i[gntIdx[o]];
      iniAddr_o[o] = iniAddr_i[gntIdx[o]];
      data_o[o]    = data_i[gntIdx[o]];
    end
  end

  // Only the granted input sees the ready of its output
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      ready_o[i] = req[outSel[i]][i] && ready_i[outSel[i]] &&
                   (gntIdx[outSel[i]] == 1'(i));
    end
  end

  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      rrPtrQ   <= '0;
      lockQ    <= '0;
      lockIdxQ <= '0;
    end else begin
      for (int o = 0; o < 2; o++) begin
        lockQ[o]    <= valid_o[o] && !ready_i[o];
        lockIdxQ[o] <= gntIdx[o];
        // Move past the winner once its flit is taken
        if (valid_o[o] && ready_i[o]) begin
          rrPtrQ[o] <= ~gntIdx[o];
        end
      end
    end
  end

endmodule

/* rtl/spillReg.sv */
// Two-entry spill register
`timescale 1ns/1ns
module spillReg
  import bflyPkg::*;
(
  input  logic clk_i,
  input  logic rstN_i,
  // Upstream side
  input  logic valid_i,
  output logic ready_o,
  input  flitT data_i,
  // Downstream side
  output logic valid_o,
  input  logic ready_i,
  output flitT data_o
);

  // Slot A takes new flits, slot B keeps the older one during a stall
  logic aFullQ;
  logic bFullQ;
  flitT aDataQ;
  flitT bDataQ;
  logic aFill;
  logic aDrain;
  logic bFill;
  logic bDrain;

  assign aFill  = valid_i && ready_o;
  assign aDrain = aFullQ && !bFullQ;
  assign bFill  = aDrain && !ready_i;
  assign bDrain = bFullQ && ready_i;

  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      aFullQ <= 1'b0;
      bFullQ <= 1'b0;
    end else begin
      if (aFill) begin
        aFullQ <= 1'b1;
      end else if (aDrain) begin
        aFullQ <= 1'b0;
      end
      if (bFill) begin
        bFullQ <= 1'b1;
      end else if (bDrain) begin
        bFullQ <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aFill) begin
      aDataQ <= data_i;
    end
    if (bFill) begin
      bDataQ <= aDataQ;
    end
  end

  // B always holds the older flit
  assign valid_o = aFullQ || bFullQ;
  assign data_o  = bFullQ ? bDataQ : aDataQ;
  assign ready_o = !aFullQ || !bFullQ;

endmodule

/* sim.f */
rtl/bflyPkg.sv
rtl/spillReg.sv
rtl/bflySwitch.sv
rtl/bflyStage.sv
rtl/bflyNet.sv
verification/bflyNetTb.sv

/* verification/bflyNetTb.sv */
// Butterfly network testbench
`timescale 1ns/1ns
module bflyNetTb
  import bflyPkg::*;
();

  localparam int ClkPeriod   = 20;
  localparam int NumRows     = 8;
  localparam int SbDepth     = 16;
  localparam int DrainCycles = 500;
  localparam int PatIdentity = 0;
  localparam int PatBitRev   = 1;
  localparam int PatHotspot  = 2;
  localparam int PatAllToAll = 3;

  logic                clk_i = 1'b0;
  logic                rstN_i;
  logic [NumPorts-1:0] valid_i;
  logic [NumPorts-1:0] ready_o;
  addrT [NumPorts-1:0] tgtAddr_i;
  dataT [NumPorts-1:0] wdata_i;
  logic [NumPorts-1:0] valid_o;
  logic [NumPorts-1:0] ready_i;
  iniT  [NumPorts-1:0] iniAddr_o;
  dataT [NumPorts-1:0] wdata_o;

  // Stimulus table of pattern, hotspot target, packets per initiator and back-pressure
  int rowPattern [NumRows] = '{PatIdentity, PatBitRev, PatHotspot, PatAllToAll,
                               PatIdentity, PatHotspot, PatAllToAll, PatBitRev};
  int rowHot     [NumRows] = '{0, 0, 5, 0, 0, 2, 0, 0};
  int rowPkts    [NumRows] = '{4, 4, 4, 8, 4, 3, 8, 4};
  int rowBp      [NumRows] = '{0, 0, 0, 0, 1, 1, 1, 1};

  // One scoreboard FIFO per (initiator, target) pair
  dataT sbData [NumPorts*NumPorts][SbDepth];
  int   sbHead [NumPorts*NumPorts];
  int   sbTail [NumPorts*NumPorts];
  int   pending   = 0;
  int   delivered = 0;
  integer seed = 69633;

  // Output values of the previous cycle for the stall hold check
  logic [NumPorts-1:0] prevStall = '0;
  dataT [NumPorts-1:0] prevData;
  iniT  [NumPorts-1:0] prevIni;

  bflyNet bflyNet_inst (
    .clk_i    (clk_i),
    .rstN_i   (rstN_i),
    .valid_i  (valid_i),
    .ready_o  (ready_o),
    .tgtAddr_i(tgtAddr_i),
    .wdata_i  (wdata_i),
    .valid_o  (valid_o),
    .ready_i  (ready_i),
    .iniAddr_o(iniAddr_o),
    .wdata_o  (wdata_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  task automatic checkEqual(input logic [63:0] actual, input logic [63:0] expected,
                            input string msg);
    if (actual !== expected) begin
      $display("error at %0t ns: %s, got %0h, expected %0h", $time, msg, actual, expected);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  function automatic int targetOf(input int pattern, input int hot, input int ini,
                                  input int seq);
    case (pattern)
      PatIdentity: return ini;
      PatBitRev:   return ((ini & 1) << 2) | (ini & 2) | ((ini >> 2) & 1);
      PatHotspot:  return hot;
      default:     return (ini + seq) % NumPorts;
    endcase
  endfunction

  // Row, initiator and sequence number make every flit unique
  function automatic dataT makeData(input int row, input int ini, input int seq);
    return dataT'((row << 16) | (ini << 8) | seq);
  endfunction

  task automatic driveFlit(input int row, input int ini, input int seq);
    tgtAddr_i[ini] = addrT'(targetOf(rowPattern[row], rowHot[row], ini, seq));
    wdata_i[ini]   = makeData(row, ini, seq);
  endtask

  task automatic updateReady(input int row);
    logic [31:0] randWord;
    if (rowBp[row] != 0) begin
      randWord = $random(seed);
      ready_i  = randWord[NumPorts-1:0];
    end else begin
      ready_i = '1;
    end
  endtask

  task automatic runRow(input int row);
    int sent [NumPorts];
    logic [NumPorts-1:0] accepted;
    int expected;
    expected = delivered + rowPkts[row] * NumPorts;
    @(posedge clk_i);
    #2;
    for (int i = 0; i < NumPorts; i++) begin
      sent[i] = 0;
      driveFlit(row, i, 0);
      valid_i[i] = 1'b1;
    end
    updateReady(row);
    while (valid_i != '0) begin
      @(negedge clk_i);
      accepted = valid_i & ready_o;
      @(posedge clk_i);
      #2;
      for (int i = 0; i < NumPorts; i++) begin
        if (accepted[i]) begin
          sent[i]++;
          if (sent[i] < rowPkts[row]) begin
            driveFlit(row, i, sent[i]);
          end else begin
            valid_i[i] = 1'b0;
          end
        end
      end
      updateReady(row);
    end
    // Drain what is still in flight
    for (int c = 0; c < DrainCycles && pending != 0; c++) begin
      @(posedge clk_i);
      #2;
      updateReady(row);
    end
    ready_i = '1;
    checkEqual(delivered, expected, $sformatf("delivered count after row %0d", row));
    for (int q = 0; q < NumPorts * NumPorts; q++) begin
      checkEqual(sbTail[q] - sbHead[q], 0, $sformatf("flits left in queue %0d", q));
    end
  endtask

  // One flit alone must reach its target one cycle after acceptance
  task automatic checkLatency(input int ini, input int tgt);
    @(posedge clk_i);
    #2;
    ready_i        = '1;
    valid_i[ini]   = 1'b1;
    tgtAddr_i[ini] = addrT'(tgt);
    wdata_i[ini]   = makeData(NumRows, ini, tgt);
    @(negedge clk_i);
    checkEqual(ready_o[ini], 1'b1, "single flit not accepted at once");
    checkEqual(valid_o[tgt], 1'b0, "single flit arrived without a register");
    @(posedge clk_i);
    #2;
    valid_i[ini] = 1'b0;
    @(negedge clk_i);
    checkEqual(valid_o[tgt], 1'b1, "single flit late at its target");
    checkEqual(iniAddr_o[tgt], ini, "single flit initiator tag");
    @(posedge clk_i);
  endtask

  // Scoreboard and hold checks sampled mid-cycle
  always @(negedge clk_i) begin
    int q;
    if (rstN_i) begin
      for (int i = 0; i < NumPorts; i++) begin
        if (valid_i[i] && ready_o[i]) begin
          q = i * NumPorts + tgtAddr_i[i];
          sbData[q][sbTail[q] % SbDepth] = wdata_i[i];
          sbTail[q]++;
          pending++;
        end
      end
      for (int j = 0; j < NumPorts; j++) begin
        if (prevStall[j]) begin
          checkEqual(valid_o[j], 1'b1, $sformatf("valid dropped during stall at %0d", j));
          checkEqual(wdata_o[j], prevData[j], $sformatf("data changed in stall at %0d", j));
          checkEqual(iniAddr_o[j], prevIni[j], $sformatf("tag changed in stall at %0d", j));
        end
        if (valid_o[j] && ready_i[j]) begin
          q = iniAddr_o[j] * NumPorts + j;
          checkEqual(sbTail[q] > sbHead[q], 1'b1,
                     $sformatf("unexpected flit at target %0d from %0d", j, iniAddr_o[j]));
          checkEqual(wdata_o[j], sbData[q][sbHead[q] % SbDepth],
                     $sformatf("data at target %0d from %0d", j, iniAddr_o[j]));
          sbHead[q]++;
          pending--;
          delivered++;
        end
        prevStall[j] = valid_o[j] && !ready_i[j];
        prevData[j]  = wdata_o[j];
        prevIni[j]   = iniAddr_o[j];
      end
    end
  end

  // Watchdog sized from the table
  initial begin
    int limitCycles;
    limitCycles = 200;
    for (int r = 0; r < NumRows; r++) begin
      limitCycles += rowPkts[r] * NumPorts * NumPorts * 40;
    end
    #(limitCycles * ClkPeriod);
    $display("Timeout: the run did not finish within %0d cycles", limitCycles);
    $display("Something failed");
    $fatal(1);
  end

  initial begin
    rstN_i    = 1'b0;
    valid_i   = '0;
    tgtAddr_i = '0;
    wdata_i   = '0;
    ready_i   = '1;
    repeat (4) @(posedge clk_i);
    #2;
    rstN_i = 1'b1;
    @(negedge clk_i);
    checkEqual(valid_o, '0, "valid_o not low after reset");
    for (int r = 0; r < NumRows; r++) begin
      runRow(r);
    end
    checkLatency(0, 7);
    checkLatency(3, 3);
    checkLatency(6, 1);
    $display("Everything OK");
    $finish;
  end

endmodule
